/* pixelPkg.sv */
// Pixel back end shared definitions
// Widths, pixel and block formats, blend and block-operation codes
`default_nettype none

package pixelPkg;

	// ------------------------------
	// Geometry
	// ------------------------------
	localparam int PIXELS_PER_BLOCK = 16;
	// Pair index inside one block
	localparam int PAIR_ID_W        = 3;
	// 9 bits of Y, then X / 16
	localparam int BLOCK_ADR_W      = 15;
	localparam int SCR_X_W          = 10;
	localparam int SCR_Y_W          = 9;

	// ------------------------------
	// Pixel formats
	// ------------------------------
	// Gouraud input color
	typedef struct packed {
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} rgb8_t;

	// 15-bit color plus mask, mask on top
	typedef struct packed {
		logic       mask;
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} pixelFields_t;

	// Memory half-word or decoded fields
	typedef union packed {
		logic [15:0]  raw;
		pixelFields_t fields;
	} pixel15_u;

	// Whole background block, pixel 0 in the low half-word
	typedef logic [PIXELS_PER_BLOCK-1:0][15:0] blockWord_t;

	// ------------------------------
	// Codes
	// ------------------------------
	// Results clamped to 0..31
	typedef enum logic [1:0] {
		AVERAGE     = 2'd0,
		ADD         = 2'd1,
		SUBTRACT    = 2'd2,
		ADD_QUARTER = 2'd3
	} blendMode_e;

	// Block operation for the memory side
	typedef enum logic [1:0] {
		NONE  = 2'b00,
		FIRST = 2'b01,
		NEXT  = 2'b10,
		FLUSH = 2'b11
	} blockCode_e;

endpackage

`default_nettype wire

/* pairWriteIf.sv */
// One pixel pair write from the blend stage
// Consumed by the block cache and mirrored on the stencil port
`timescale 1ns/1ns
`default_nettype none

interface pairWriteIf
	import pixelPkg::*;
();

	// Applied at the next edge, no handshake
	logic                   write;
	logic [PAIR_ID_W-1:0]   pairId;
	// Bit 1 right pixel, bit 0 left pixel
	logic [1:0]             select;
	pixel15_u               dataL;
	pixel15_u               dataR;
	logic [BLOCK_ADR_W-1:0] blockAdr;

	// Blend stage side
	modport source (output write, pairId, select, dataL, dataR, blockAdr);

	// Block cache side
	modport sink (input write, pairId, select, dataL, dataR, blockAdr);

	// Stencil observers
	modport monitor (input write, pairId, select, dataL, dataR, blockAdr);

endinterface

`default_nettype wire

/* pairBlendStage.sv */
// Pair register stage with color reduction and background blending
// Forms the pair write for the block cache
`timescale 1ns/1ns
`default_nettype none

module pairBlendStage
	import pixelPkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   i_reset,
	input  wire logic                   i_pause,
	input  wire logic                   i_pairValid,
	input  wire logic [1:0]             i_pixelState,
	input  wire logic [SCR_X_W-1:0]     i_scrX,
	input  wire logic [SCR_Y_W-1:0]     i_scrY,
	input  wire rgb8_t                  i_colorL,
	input  wire rgb8_t                  i_colorR,
	input  wire logic                   i_validL,
	input  wire logic                   i_validR,
	input  wire logic                   i_maskL,
	input  wire logic                   i_maskR,
	input  wire blendMode_e             i_blendMode,
	input  wire logic                   i_noBlend,
	input  wire logic                   i_forceMask,
	input  wire pixel15_u               i_bgL,
	input  wire pixel15_u               i_bgR,
	output      logic [1:0]             o_stageState,
	output      logic [BLOCK_ADR_W-1:0] o_stageAdr,
	pairWriteIf.source                  wr
);

	// Clamped blend of one 5-bit channel
	function automatic logic [4:0] blendChannel(input logic [4:0] bg, input logic [4:0] fg,
		input blendMode_e mode);
		logic signed [6:0] bg7;
		logic signed [6:0] fg7;
		logic signed [6:0] sum;
		bg7 = {2'b00, bg};
		fg7 = {2'b00, fg};
		case (mode)
			AVERAGE:     sum = (bg7 >>> 1) + (fg7 >>> 1);
			ADD:         sum = bg7 + fg7;
			SUBTRACT:    sum = bg7 - fg7;
			ADD_QUARTER: sum = bg7 + (fg7 >>> 2);
			default:     sum = fg7;
		endcase
		if (sum < 0)
			return 5'd0;
		if (sum > 31)
			return 5'd31;
		return sum[4:0];
	endfunction

	// Reduce to 5 bits, blend if enabled, merge mask
	function automatic pixel15_u formPixel(input rgb8_t color, input logic mask,
		input pixel15_u bg, input blendMode_e mode, input logic noBlend, input logic forceMask);
		pixel15_u px;
		px.fields.mask = mask | forceMask;
		if (noBlend) begin
			px.fields.red   = color.red[7:3];
			px.fields.green = color.green[7:3];
			px.fields.blue  = color.blue[7:3];
		end else begin
			px.fields.red   = blendChannel(bg.fields.red,   color.red[7:3],   mode);
			px.fields.green = blendChannel(bg.fields.green, color.green[7:3], mode);
			px.fields.blue  = blendChannel(bg.fields.blue,  color.blue[7:3],  mode);
		end
		return px;
	endfunction

	// ------------------------------
	// Stage register
	// ------------------------------
	logic                 stageValid;
	logic [1:0]           stageState;
	// Pair X is the left pixel X with bit 0 dropped
	logic [SCR_X_W-2:0]   stPairX;
	logic [SCR_Y_W-1:0]   stY;
	rgb8_t                stColorL;
	rgb8_t                stColorR;
	logic                 stValidL;
	logic                 stValidR;
	logic                 stMaskL;
	logic                 stMaskR;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			stageValid <= 1'b0;
			stageState <= 2'b00;
		end else if (!i_pause) begin
			stageValid <= i_pairValid;
			stageState <= i_pairValid ? i_pixelState : 2'b00;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_pause && i_pairValid) begin
			stPairX  <= i_scrX[SCR_X_W-1:1];
			stY      <= i_scrY;
			stColorL <= i_colorL;
			stColorR <= i_colorR;
			stValidL <= i_validL;
			stValidR <= i_validR;
			stMaskL  <= i_maskL;
			stMaskR  <= i_maskR;
		end
	end

	// ------------------------------
	// Write formation
	// ------------------------------
	assign o_stageState = stageState;
	// Y then X / 16
	assign o_stageAdr   = {stY, stPairX[SCR_X_W-2:PAIR_ID_W]};

	// Pause blocks the write combinationally
	assign wr.write    = stageValid & (stValidL | stValidR) & !i_pause;
	assign wr.pairId   = stPairX[PAIR_ID_W-1:0];
	assign wr.select   = {stValidR, stValidL};
	assign wr.blockAdr = o_stageAdr;
	assign wr.dataL    = formPixel(stColorL, stMaskL, i_bgL, i_blendMode, i_noBlend, i_forceMask);
	assign wr.dataR    = formPixel(stColorR, stMaskR, i_bgR, i_blendMode, i_noBlend, i_forceMask);

	// Same pair index next cycle blends over the result just written
	assert property (@(posedge clk) disable iff (i_reset)
		($past(wr.write && wr.select[0]) && (wr.pairId == $past(wr.pairId)))
			|-> (i_bgL == $past(wr.dataL)))
		else $error("left background misses the previous write");

	assert property (@(posedge clk) disable iff (i_reset)
		($past(wr.write && wr.select[1]) && (wr.pairId == $past(wr.pairId)))
			|-> (i_bgR == $past(wr.dataR)))
		else $error("right background misses the previous write");

endmodule

`default_nettype wire

/* blockCache.sv */
// 16-pixel background block cache
// Pair writes, written mask, background read, import and last write address
`timescale 1ns/1ns
`default_nettype none

module blockCache
	import pixelPkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    i_reset,
	pairWriteIf.sink                     rd,
	input  wire logic                    i_importBlock,
	input  wire blockWord_t              i_importData,
	input  wire logic                    i_resetMask,
	output      pixel15_u                o_bgL,
	output      pixel15_u                o_bgR,
	output      blockWord_t              o_block,
	output      logic [PIXELS_PER_BLOCK-1:0] o_mask,
	output      logic [BLOCK_ADR_W-1:0]  o_lastAdr
);

	blockWord_t                   cacheBlk;
	logic [PIXELS_PER_BLOCK-1:0]  cacheMask;
	logic [BLOCK_ADR_W-1:0]       lastAdr;

	// Half-word index of each pixel of the pair
	logic [PAIR_ID_W:0] idxL;
	logic [PAIR_ID_W:0] idxR;

	assign idxL = {rd.pairId, 1'b0};
	assign idxR = {rd.pairId, 1'b1};

	// ------------------------------
	// Background read for blending
	// ------------------------------
	assign o_bgL = cacheBlk[idxL];
	assign o_bgR = cacheBlk[idxR];

	// ------------------------------
	// Block data
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rd.write) begin
			if (rd.select[0])
				cacheBlk[idxL] <= rd.dataL.raw;
			if (rd.select[1])
				cacheBlk[idxR] <= rd.dataR.raw;
		end else if (i_importBlock) begin
			// Whole block in one cycle
			cacheBlk <= i_importData;
		end
	end

	// Written mask and save address
	always_ff @(posedge clk) begin
		if (i_reset) begin
			cacheMask <= '0;
			lastAdr   <= '0;
		end else if (rd.write) begin
			lastAdr <= rd.blockAdr;
			if (rd.select[0])
				cacheMask[idxL] <= 1'b1;
			if (rd.select[1])
				cacheMask[idxR] <= 1'b1;
		end else if (i_resetMask) begin
			cacheMask <= '0;
		end
	end

	assign o_block   = cacheBlk;
	assign o_mask    = cacheMask;
	assign o_lastAdr = lastAdr;

	// Stage only writes pairs with a valid pixel
	assert property (@(posedge clk) disable iff (i_reset)
		rd.write |-> (rd.select != 2'b00))
		else $error("pair write with empty select");

endmodule

`default_nettype wire

/* blockSequencer.sv */
// Block operation FSM for the memory side
// Forms the block code and the new-block flag
`timescale 1ns/1ns
`default_nettype none

module blockSequencer
	import pixelPkg::*;
(
	input  wire logic       clk,
	input  wire logic       i_reset,
	input  wire logic       i_pause,
	input  wire logic [1:0] i_stageState,
	input  wire logic       i_noBlend,
	input  wire logic       i_flush,
	input  wire logic       i_resetSpike,
	output      blockCode_e o_code,
	output      logic       o_newBlock
);

	localparam logic [1:0] IDLE     = 2'd0;
	localparam logic [1:0] OPEN     = 2'd1;
	localparam logic [1:0] FLUSHING = 2'd2;

	logic [1:0] state;
	logic [1:0] nextState;
	logic       newFlag;

	// ------------------------------
	// Code and next state
	// ------------------------------
	always_comb begin
		o_code    = NONE;
		nextState = state;
		if (state == FLUSHING) begin
			// One cycle only
			nextState = IDLE;
		end
		if (!i_pause) begin
			if (i_flush && state == OPEN) begin
				o_code    = FLUSH;
				nextState = FLUSHING;
			end else begin
				// First block with blending off needs no load
				if (i_stageState == FIRST && i_noBlend)
					o_code = NONE;
				else
					o_code = blockCode_e'(i_stageState);
				if (state == IDLE && i_stageState == FIRST)
					nextState = OPEN;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	// Sticky until the reset spike, new code wins
	always_ff @(posedge clk) begin
		if (i_reset)
			newFlag <= 1'b0;
		else if (o_code != NONE)
			newFlag <= 1'b1;
		else if (i_resetSpike)
			newFlag <= 1'b0;
	end

	assign o_newBlock = newFlag | (o_code != NONE);

endmodule

`default_nettype wire

/* saveHoldTimer.sv */
// Holds the block code on the memory port for a fixed cycle count
`timescale 1ns/1ns
`default_nettype none

module saveHoldTimer
	import pixelPkg::*;
#(
	parameter int HOLD_CYCLES = 4
) (
	input  wire logic       clk,
	input  wire logic       i_reset,
	input  wire blockCode_e i_code,
	output      blockCode_e o_saveBlock
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	blockCode_e       holdCode;
	logic [CNT_W-1:0] holdCnt;

	// New code restarts the count
	always_ff @(posedge clk) begin
		if (i_reset) begin
			holdCode <= NONE;
			holdCnt  <= '0;
		end else if (i_code != NONE) begin
			holdCode <= i_code;
			holdCnt  <= CNT_W'(HOLD_CYCLES);
		end else if (holdCnt != '0) begin
			holdCnt <= holdCnt - 1'b1;
		end
	end

	assign o_saveBlock = (holdCnt != '0) ? holdCode : NONE;

endmodule

`default_nettype wire

/* pixelBackend.sv */
// Pixel back end write path top level
// Blend stage, background block cache, block sequencer and save timer
`timescale 1ns/1ns
`default_nettype none

module pixelBackend
	import pixelPkg::*;
#(
	parameter int SAVE_HOLD_CYCLES = 4
) (
	input  wire logic                        clk,
	input  wire logic                        i_reset,
	input  wire logic                        i_pause,
	input  wire logic                        i_pairValid,
	input  wire logic [1:0]                  i_pixelState,
	input  wire logic [SCR_X_W-1:0]          i_scrX,
	input  wire logic [SCR_Y_W-1:0]          i_scrY,
	input  wire rgb8_t                       i_colorL,
	input  wire rgb8_t                       i_colorR,
	input  wire logic                        i_validL,
	input  wire logic                        i_validR,
	input  wire logic                        i_maskL,
	input  wire logic                        i_maskR,
	input  wire blendMode_e                  i_blendMode,
	input  wire logic                        i_noBlend,
	input  wire logic                        i_forceMask,
	input  wire logic                        i_flush,
	input  wire logic                        i_resetSpike,
	input  wire logic                        i_resetMask,
	input  wire logic                        i_importBlock,
	input  wire blockWord_t                  i_importData,
	output      logic                        o_stencilWrite,
	output      logic [BLOCK_ADR_W-1:0]      o_stencilAdr,
	output      logic [PAIR_ID_W-1:0]        o_stencilPair,
	output      logic [1:0]                  o_stencilSelect,
	output      logic [1:0]                  o_stencilValue,
	output      blockCode_e                  o_saveBlock,
	output      logic [BLOCK_ADR_W-1:0]      o_saveAdr,
	output      logic [BLOCK_ADR_W-1:0]      o_loadAdr,
	output      blockWord_t                  o_exportBlock,
	output      logic [PIXELS_PER_BLOCK-1:0] o_exportMask,
	output      logic                        o_newBlock
);

	pairWriteIf wrIf ();

	pixel15_u   bgL;
	pixel15_u   bgR;
	logic [1:0] stageState;
	blockCode_e blockCode;

	pairBlendStage u_stage (
		.clk(clk), .i_reset(i_reset), .i_pause(i_pause),
		.i_pairValid(i_pairValid), .i_pixelState(i_pixelState),
		.i_scrX(i_scrX), .i_scrY(i_scrY),
		.i_colorL(i_colorL), .i_colorR(i_colorR),
		.i_validL(i_validL), .i_validR(i_validR),
		.i_maskL(i_maskL), .i_maskR(i_maskR),
		.i_blendMode(i_blendMode), .i_noBlend(i_noBlend), .i_forceMask(i_forceMask),
		.i_bgL(bgL), .i_bgR(bgR),
		.o_stageState(stageState), .o_stageAdr(o_loadAdr),
		.wr(wrIf)
	);

	blockCache u_cache (
		.clk(clk), .i_reset(i_reset), .rd(wrIf),
		.i_importBlock(i_importBlock), .i_importData(i_importData),
		.i_resetMask(i_resetMask),
		.o_bgL(bgL), .o_bgR(bgR),
		.o_block(o_exportBlock), .o_mask(o_exportMask), .o_lastAdr(o_saveAdr)
	);

	blockSequencer u_seq (
		.clk(clk), .i_reset(i_reset), .i_pause(i_pause),
		.i_stageState(stageState), .i_noBlend(i_noBlend), .i_flush(i_flush),
		.i_resetSpike(i_resetSpike),
		.o_code(blockCode), .o_newBlock(o_newBlock)
	);

	saveHoldTimer #(
		.HOLD_CYCLES(SAVE_HOLD_CYCLES)
	) u_saveTimer (
		.clk(clk), .i_reset(i_reset),
		.i_code(blockCode), .o_saveBlock(o_saveBlock)
	);

	// ------------------------------
	// Stencil port, monitor view of the pair write
	// ------------------------------
	assign o_stencilWrite  = wrIf.write;
	assign o_stencilAdr    = wrIf.blockAdr;
	assign o_stencilPair   = wrIf.pairId;
	assign o_stencilSelect = wrIf.select;
	assign o_stencilValue  = {wrIf.dataR.fields.mask, wrIf.dataL.fields.mask};

endmodule

`default_nettype wire

/* tb_pixelBackend.sv */
// Random testbench for the pixel back end write path
// Checks block data, mask, stencil port and block codes against a model
`timescale 1ns/1ns
`default_nettype none

module tb_pixelBackend
	import pixelPkg::*;
();

	localparam int SAVE_HOLD    = 4;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_PAIRS    = 200;
	localparam int DRAIN_CYCLES = 12;
	// Roughly two cycles per pair on average so four per pair is a wide margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * NUM_PAIRS + DRAIN_CYCLES + 50;

	localparam logic [1:0] SEQ_IDLE     = 2'd0;
	localparam logic [1:0] SEQ_OPEN     = 2'd1;
	localparam logic [1:0] SEQ_FLUSHING = 2'd2;

	logic clk;
	logic i_reset;
	logic i_pause;
	logic i_pairValid;
	logic [1:0] i_pixelState;
	logic [SCR_X_W-1:0] i_scrX;
	logic [SCR_Y_W-1:0] i_scrY;
	rgb8_t i_colorL;
	rgb8_t i_colorR;
	logic i_validL;
	logic i_validR;
	logic i_maskL;
	logic i_maskR;
	blendMode_e i_blendMode;
	logic i_noBlend;
	logic i_forceMask;
	logic i_flush;
	logic i_resetSpike;
	logic i_resetMask;
	logic i_importBlock;
	blockWord_t i_importData;
	logic o_stencilWrite;
	logic [BLOCK_ADR_W-1:0] o_stencilAdr;
	logic [PAIR_ID_W-1:0] o_stencilPair;
	logic [1:0] o_stencilSelect;
	logic [1:0] o_stencilValue;
	blockCode_e o_saveBlock;
	logic [BLOCK_ADR_W-1:0] o_saveAdr;
	logic [BLOCK_ADR_W-1:0] o_loadAdr;
	blockWord_t o_exportBlock;
	logic [PIXELS_PER_BLOCK-1:0] o_exportMask;
	logic o_newBlock;

	integer seed = 82363;
	int cycleCount = 0;
	int pairsAccepted = 0;

	// ------------------------------
	// Model state
	// ------------------------------
	// Stage register
	logic mStageValid;
	logic mStageLoaded;
	logic [1:0] mStageState;
	logic [SCR_X_W-2:0] mPairX;
	logic [SCR_Y_W-1:0] mY;
	rgb8_t mColorL;
	rgb8_t mColorR;
	logic mValidL;
	logic mValidR;
	logic mMaskL;
	logic mMaskR;
	// Cache contents
	blockWord_t mBlock;
	logic mBlockKnown;
	logic [PIXELS_PER_BLOCK-1:0] mMask;
	logic [BLOCK_ADR_W-1:0] mLastAdr;
	// Sequencer and hold counter
	logic [1:0] mSeqState;
	logic mNewFlag;
	blockCode_e mHoldCode;
	int mHoldCnt;

	pixelBackend #(
		.SAVE_HOLD_CYCLES(SAVE_HOLD)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// Failure and compare tasks
	// ------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkAdr(input string name, input logic [BLOCK_ADR_W-1:0] got,
		input logic [BLOCK_ADR_W-1:0] exp);
		if (got !== exp)
			failRun($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkMask(input string name, input logic [PIXELS_PER_BLOCK-1:0] got,
		input logic [PIXELS_PER_BLOCK-1:0] exp);
		if (got !== exp)
			failRun($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkCode(input string name, input blockCode_e got, input blockCode_e exp);
		if (got !== exp)
			failRun($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkPixel(input string name, input pixel15_u got, input pixel15_u exp);
		if (got.raw !== exp.raw)
			failRun($sformatf("error: %s got %h expected %h", name, got.raw, exp.raw));
	endtask

	// Per pixel so the error line names the half-word
	task automatic checkBlock(input string name, input blockWord_t got, input blockWord_t exp);
		int i;
		for (i = 0; i < PIXELS_PER_BLOCK; i++)
			checkPixel($sformatf("%s[%0d]", name, i), got[i], exp[i]);
	endtask

	task automatic checkStencil(input logic [BLOCK_ADR_W-1:0] adr, input logic [PAIR_ID_W-1:0] pair,
		input logic [1:0] sel, input logic [1:0] value);
		checkAdr("o_stencilAdr", o_stencilAdr, adr);
		if (o_stencilPair !== pair)
			failRun($sformatf("error: o_stencilPair got %h expected %h", o_stencilPair, pair));
		if (o_stencilSelect !== sel)
			failRun($sformatf("error: o_stencilSelect got %h expected %h", o_stencilSelect, sel));
		if (o_stencilValue !== value)
			failRun($sformatf("error: o_stencilValue got %h expected %h", o_stencilValue, value));
	endtask

	// ------------------------------
	// Blend rules
	// ------------------------------
	function automatic logic [4:0] mixChannel(input int bgv, input int fgv, input blendMode_e mode);
		int r;
		case (mode)
			AVERAGE:  r = bgv / 2 + fgv / 2;
			ADD:      r = bgv + fgv;
			SUBTRACT: r = bgv - fgv;
			default:  r = bgv + fgv / 4;
		endcase
		if (r < 0)
			r = 0;
		else if (r > 31)
			r = 31;
		return r[4:0];
	endfunction

	// 8-bit channels lose their low 3 bits
	function automatic pixel15_u expectedPixel(input rgb8_t color, input logic maskIn,
		input pixel15_u bg, input blendMode_e mode, input logic noBlend, input logic maskForce);
		pixel15_u px;
		int fgR;
		int fgG;
		int fgB;
		fgR = int'(color.red[7:3]);
		fgG = int'(color.green[7:3]);
		fgB = int'(color.blue[7:3]);
		px.fields.mask = maskIn | maskForce;
		if (noBlend) begin
			px.fields.red   = fgR[4:0];
			px.fields.green = fgG[4:0];
			px.fields.blue  = fgB[4:0];
		end else begin
			px.fields.red   = mixChannel(int'(bg.fields.red), fgR, mode);
			px.fields.green = mixChannel(int'(bg.fields.green), fgG, mode);
			px.fields.blue  = mixChannel(int'(bg.fields.blue), fgB, mode);
		end
		return px;
	endfunction

	// ------------------------------
	// Model step once per cycle at the falling edge
	// ------------------------------
	task automatic resetModel();
		mStageValid  = 1'b0;
		mStageLoaded = 1'b0;
		mStageState  = 2'b00;
		mBlockKnown  = 1'b0;
		mMask        = '0;
		mLastAdr     = '0;
		mSeqState    = SEQ_IDLE;
		mNewFlag     = 1'b0;
		mHoldCode    = NONE;
		mHoldCnt     = 0;
	endtask

	task automatic stepModel();
		logic expWrite;
		logic [PAIR_ID_W-1:0] pairId;
		logic [PAIR_ID_W:0] idxL;
		logic [PAIR_ID_W:0] idxR;
		logic [BLOCK_ADR_W-1:0] expAdr;
		pixel15_u expL;
		pixel15_u expR;
		blockCode_e expCode;
		blockCode_e expSave;
		logic [1:0] nextSeq;
		expWrite = mStageValid && (mValidL || mValidR) && !i_pause;
		pairId   = mPairX[PAIR_ID_W-1:0];
		idxL     = {pairId, 1'b0};
		idxR     = {pairId, 1'b1};
		expAdr   = {mY, mPairX[SCR_X_W-2:PAIR_ID_W]};
		expL = expectedPixel(mColorL, mMaskL, mBlock[idxL], i_blendMode, i_noBlend, i_forceMask);
		expR = expectedPixel(mColorR, mMaskR, mBlock[idxR], i_blendMode, i_noBlend, i_forceMask);

		// Block code of this cycle
		expCode = NONE;
		nextSeq = (mSeqState == SEQ_FLUSHING) ? SEQ_IDLE : mSeqState;
		if (!i_pause) begin
			if (i_flush && mSeqState == SEQ_OPEN) begin
				expCode = FLUSH;
				nextSeq = SEQ_FLUSHING;
			end else begin
				// FIRST without blending needs no background load
				if (!(mStageState == 2'b01 && i_noBlend))
					expCode = blockCode_e'(mStageState);
				if (mSeqState == SEQ_IDLE && mStageState == 2'b01)
					nextSeq = SEQ_OPEN;
			end
		end
		expSave = (mHoldCnt > 0) ? mHoldCode : NONE;

		// Outputs of this cycle
		checkFlag("o_stencilWrite", o_stencilWrite, expWrite);
		if (expWrite)
			checkStencil(expAdr, pairId, {mValidR, mValidL},
				{mMaskR | i_forceMask, mMaskL | i_forceMask});
		checkCode("o_saveBlock", o_saveBlock, expSave);
		checkFlag("o_newBlock", o_newBlock, mNewFlag || (expCode != NONE));
		checkAdr("o_saveAdr", o_saveAdr, mLastAdr);
		if (mStageLoaded)
			checkAdr("o_loadAdr", o_loadAdr, expAdr);
		checkMask("o_exportMask", o_exportMask, mMask);
		if (mBlockKnown)
			checkBlock("o_exportBlock", o_exportBlock, mBlock);

		// Cache update where import and mask clear lose to a write
		if (expWrite) begin
			if (mValidL) begin
				mBlock[idxL] = expL.raw;
				mMask[idxL]  = 1'b1;
			end
			if (mValidR) begin
				mBlock[idxR] = expR.raw;
				mMask[idxR]  = 1'b1;
			end
			mLastAdr = expAdr;
		end else begin
			if (i_importBlock) begin
				mBlock      = i_importData;
				mBlockKnown = 1'b1;
			end
			if (i_resetMask)
				mMask = '0;
		end

		mSeqState = nextSeq;
		if (expCode != NONE)
			mNewFlag = 1'b1;
		else if (i_resetSpike)
			mNewFlag = 1'b0;

		// Hold counter restarts on any code
		if (expCode != NONE) begin
			mHoldCode = expCode;
			mHoldCnt  = SAVE_HOLD;
		end else if (mHoldCnt > 0) begin
			mHoldCnt = mHoldCnt - 1;
		end

		// Stage register frozen by pause
		if (!i_pause) begin
			mStageValid = i_pairValid;
			mStageState = i_pairValid ? i_pixelState : 2'b00;
			if (i_pairValid) begin
				mPairX        = i_scrX[SCR_X_W-1:1];
				mY            = i_scrY;
				mColorL       = i_colorL;
				mColorR       = i_colorR;
				mValidL       = i_validL;
				mValidR       = i_validR;
				mMaskL        = i_maskL;
				mMaskR        = i_maskR;
				mStageLoaded  = 1'b1;
				pairsAccepted = pairsAccepted + 1;
			end
		end
	endtask

	always @(negedge clk) begin
		if (i_reset)
			resetModel();
		else
			stepModel();
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > TIMEOUT_CYCLES)
			failRun($sformatf("timeout: test did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	// True with a chance of pct in 100
	function automatic logic chance(input int pct);
		logic [31:0] r;
		r = randomWord();
		return (r % 32'd100) < pct;
	endfunction

	function automatic blockWord_t randomBlock();
		blockWord_t b;
		logic [31:0] r;
		int i;
		for (i = 0; i < PIXELS_PER_BLOCK; i++) begin
			r    = randomWord();
			b[i] = r[15:0];
		end
		return b;
	endfunction

	task automatic driveRandomCycle();
		logic [31:0] r;
		r = randomWord();
		i_pause       <= chance(20);
		i_pairValid   <= chance(70);
		i_pixelState  <= chance(50) ? 2'b01 : 2'b10;
		i_scrX        <= r[SCR_X_W-1:0];
		i_scrY        <= r[SCR_X_W+SCR_Y_W-1:SCR_X_W];
		i_blendMode   <= blendMode_e'(r[31:30]);
		i_colorL      <= rgb8_t'(randomWord());
		i_colorR      <= rgb8_t'(randomWord());
		i_validL      <= chance(80);
		i_validR      <= chance(80);
		i_maskL       <= chance(30);
		i_maskR       <= chance(30);
		i_noBlend     <= chance(30);
		i_forceMask   <= chance(20);
		i_flush       <= chance(8);
		i_resetSpike  <= chance(15);
		i_resetMask   <= chance(8);
		i_importBlock <= chance(4);
		i_importData  <= randomBlock();
	endtask

	// No new work so the hold counter runs out
	task automatic driveIdleCycle();
		i_pause       <= 1'b0;
		i_pairValid   <= 1'b0;
		i_flush       <= 1'b0;
		i_resetSpike  <= 1'b0;
		i_resetMask   <= 1'b0;
		i_importBlock <= 1'b0;
	endtask

	initial begin
		i_reset       = 1'b1;
		i_pause       = 1'b0;
		i_pairValid   = 1'b0;
		i_pixelState  = 2'b00;
		i_scrX        = '0;
		i_scrY        = '0;
		i_colorL      = '0;
		i_colorR      = '0;
		i_validL      = 1'b0;
		i_validR      = 1'b0;
		i_maskL       = 1'b0;
		i_maskR       = 1'b0;
		i_blendMode   = AVERAGE;
		i_noBlend     = 1'b0;
		i_forceMask   = 1'b0;
		i_flush       = 1'b0;
		i_resetSpike  = 1'b0;
		i_resetMask   = 1'b0;
		i_importBlock = 1'b0;
		i_importData  = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		// Defined background before the first pair
		i_reset       <= 1'b0;
		i_importBlock <= 1'b1;
		i_importData  <= randomBlock();

		while (pairsAccepted < NUM_PAIRS) begin
			@(posedge clk);
			driveRandomCycle();
		end

		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			driveIdleCycle();
		end
		@(negedge clk);
		@(posedge clk);

		$display("%0d pairs accepted in %0d cycles", pairsAccepted, cycleCount);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
pixelPkg.sv
pairWriteIf.sv
pairBlendStage.sv
blockCache.sv
blockSequencer.sv
saveHoldTimer.sv
pixelBackend.sv
tb_pixelBackend.sv

/* run.sh */
#!/bin/sh
# Build and run the pixel back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_pixelBackend -o tb_pixelBackend
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pixelBackend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
